//--- hdl/fe_consts.svh
`ifndef FE_CONSTS_SVH
`define FE_CONSTS_SVH

//////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////
`define FE_XLEN 32 // address and instruction width

// first fetch address out of reset
`define FE_RESET_PC 32'h1c000000

// pair entries in the instruction queue, power of two
`define FE_QUEUE_DEPTH 4

//////////////////////////////////////////////////
// instruction fields
//////////////////////////////////////////////////
`define FE_OPC_MSB 31 // major opcode
`define FE_OPC_LSB 26
`define FE_OFFS_BITS 26 // b/bl offset, low16 at 25..10, high10 at 9..0

`endif

//--- hdl/fe_pkg.sv
`default_nettype none

`include "fe_consts.svh"

package fe_pkg;

    // exception code carried with a fetched slot
    typedef enum logic [5:0] {
        ECODE_NONE = 6'd0,
        ECODE_ADEF = 6'd8 // fetch address not word aligned
    } fe_ecode_e;

    // major opcodes the predecoder cares about
    typedef enum logic [5:0] {
        OP_OTHER = 6'b000000,
        OP_B     = 6'b010100,
        OP_BL    = 6'b010101
    } fe_jump_op_e;

    // one queue entry, slot 0 in ir[0]
    typedef struct packed {
        logic [`FE_XLEN-1:0]       pc;         // pair base, 8 byte aligned
        logic [1:0][`FE_XLEN-1:0]  ir;
        logic [1:0]                slot_valid;
        fe_ecode_e                 ecode;
    } fe_entry_t;

endpackage

`default_nettype wire

//--- hdl/fetch_pair_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "fe_consts.svh"

// one fetched pair, fetch stage -> instruction queue
interface fetch_pair_if;

    logic                      valid;      // push strobe
    logic [`FE_XLEN-1:0]       pc;
    logic [1:0][`FE_XLEN-1:0]  ir;
    logic [1:0]                slot_valid;
    fe_pkg::fe_ecode_e         ecode;
    logic                      full;       // queue level, no handshake

    modport producer (
        output valid, pc, ir, slot_valid, ecode,
        input  full
    );

    modport consumer (
        input  valid, pc, ir, slot_valid, ecode,
        output full
    );

endinterface

`default_nettype wire

//--- hdl/fetch_pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "fe_consts.svh"

module fetch_pc_gen (
    input  wire logic                clk,
    input  wire logic                i_arst_n,
    input  wire logic                i_exc_valid,   // exception entry
    input  wire logic [`FE_XLEN-1:0] i_eentry,
    input  wire logic                i_ertn_valid,  // exception return
    input  wire logic [`FE_XLEN-1:0] i_era,
    input  wire logic                i_br_redirect, // branch correction from execute
    input  wire logic [`FE_XLEN-1:0] i_br_target,
    input  wire logic                i_pd_redirect, // predecoded b/bl
    input  wire logic [`FE_XLEN-1:0] i_pd_target,
    input  wire logic                i_stall,
    output logic      [`FE_XLEN-1:0] o_pc,
    output logic                     o_flush
);

    localparam logic [`FE_XLEN-1:0] PAIR_BYTES = 8;

    logic [`FE_XLEN-1:0] pc_q;
    logic [`FE_XLEN-1:0] pc_seq;
    logic [`FE_XLEN-1:0] pc_nxt;

    // next pair always starts on an 8 byte boundary
    assign pc_seq = {pc_q[`FE_XLEN-1:3], 3'b000} + PAIR_BYTES;

    //////////////////////////////////////////////////
    // redirect priority
    //////////////////////////////////////////////////
    always_comb begin
        if (i_exc_valid) begin
            pc_nxt = i_eentry;
        end else if (i_ertn_valid) begin
            pc_nxt = i_era;
        end else if (i_br_redirect) begin
            pc_nxt = i_br_target;
        end else if (i_stall) begin
            pc_nxt = pc_q; // queue full, refetch same pair
        end else if (i_pd_redirect) begin
            pc_nxt = i_pd_target;
        end else begin
            pc_nxt = pc_seq;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q <= `FE_RESET_PC;
        end else begin
            pc_q <= pc_nxt;
        end
    end

    assign o_pc = pc_q;

    // any redirect from the back end kills what is in flight
    assign o_flush = i_exc_valid | i_ertn_valid | i_br_redirect;

endmodule

`default_nettype wire

//--- hdl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "fe_consts.svh"

module fetch_stage (
    input  wire logic                     clk,
    input  wire logic                     i_arst_n,
    input  wire logic [`FE_XLEN-1:0]      i_pc,
    input  wire logic [2*`FE_XLEN-1:0]    i_fetch_data, // slot 0 in the low word
    input  wire logic                     i_flush,
    output logic                          o_pd_redirect,
    output logic      [`FE_XLEN-1:0]      o_pd_target,
    fetch_pair_if.producer                pair
);

    logic [1:0]                fetch_valid;
    fe_pkg::fe_ecode_e         fetch_ecode;

    logic [1:0]                stg_valid;
    logic [`FE_XLEN-1:0]       stg_pc;
    logic [1:0][`FE_XLEN-1:0]  stg_ir;
    fe_pkg::fe_ecode_e         stg_ecode;

    logic                      pd_en;
    logic                      jump0;
    logic                      jump1;

    function automatic fe_pkg::fe_jump_op_e decode_op(input logic [`FE_XLEN-1:0] ir);
        logic [`FE_OPC_MSB-`FE_OPC_LSB:0] opc;
        opc = ir[`FE_OPC_MSB:`FE_OPC_LSB];
        case (opc)
            fe_pkg::OP_B:  decode_op = fe_pkg::OP_B;
            fe_pkg::OP_BL: decode_op = fe_pkg::OP_BL;
            default:       decode_op = fe_pkg::OP_OTHER;
        endcase
    endfunction

    // slot pc + sext(offs) * 4
    function automatic logic [`FE_XLEN-1:0] jump_target(
        input logic [`FE_XLEN-1:0] pc,
        input logic [`FE_XLEN-1:0] ir
    );
        logic [`FE_OFFS_BITS-1:0] offs;
        offs = {ir[9:0], ir[25:10]};
        jump_target = pc + {{(`FE_XLEN-`FE_OFFS_BITS-2){offs[`FE_OFFS_BITS-1]}}, offs, 2'b00};
    endfunction

    //////////////////////////////////////////////////
    // fetch side
    //////////////////////////////////////////////////
    assign fetch_valid = i_pc[2] ? 2'b10 : 2'b11; // odd word start drops slot 0
    assign fetch_ecode = (i_pc[1:0] != 2'b00) ? fe_pkg::ECODE_ADEF : fe_pkg::ECODE_NONE;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            stg_valid <= 2'b00;
        end else if (i_flush) begin
            stg_valid <= 2'b00;
        end else if (!pair.full) begin
            stg_valid <= o_pd_redirect ? 2'b00 : fetch_valid; // drop wrong path
        end
    end

    always_ff @(posedge clk) begin
        if (!pair.full) begin
            stg_pc    <= {i_pc[`FE_XLEN-1:3], 3'b000};
            stg_ir    <= i_fetch_data;
            stg_ecode <= fetch_ecode;
        end
    end

    //////////////////////////////////////////////////
    // predecode b/bl on the stage pair
    //////////////////////////////////////////////////
    assign pd_en = (stg_ecode == fe_pkg::ECODE_NONE); // misaligned pair is ignored
    assign jump0 = pd_en & stg_valid[0] & (decode_op(stg_ir[0]) != fe_pkg::OP_OTHER);
    assign jump1 = pd_en & stg_valid[1] & (decode_op(stg_ir[1]) != fe_pkg::OP_OTHER);

    assign o_pd_redirect = jump0 | jump1;
    assign o_pd_target   = jump0 ? jump_target(stg_pc, stg_ir[0])
                                 : jump_target(stg_pc + 32'd4, stg_ir[1]);

    assign pair.slot_valid = jump0 ? {1'b0, stg_valid[0]} : stg_valid; // trim younger slot
    assign pair.valid      = |stg_valid;
    assign pair.pc         = stg_pc;
    assign pair.ir         = stg_ir;
    assign pair.ecode      = stg_ecode;

endmodule

`default_nettype wire

//--- hdl/inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "fe_consts.svh"

module inst_queue #(
    parameter int DEPTH = `FE_QUEUE_DEPTH
) (
    input  wire logic                clk,
    input  wire logic                i_arst_n,
    input  wire logic                i_flush,
    input  wire logic                i_issue_ready,
    fetch_pair_if.consumer           pair,
    output logic      [1:0]          o_issue_valid,
    output logic      [`FE_XLEN-1:0] o_issue_pc0,
    output logic      [`FE_XLEN-1:0] o_issue_pc1,
    output logic      [`FE_XLEN-1:0] o_issue_ir0,
    output logic      [`FE_XLEN-1:0] o_issue_ir1,
    output fe_pkg::fe_ecode_e        o_issue_ecode
);

    localparam int PTR_W = $clog2(DEPTH);

    fe_pkg::fe_entry_t  mem [DEPTH];
    fe_pkg::fe_entry_t  head;
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;
    logic               empty;
    logic               push;
    logic               pop;

    assign empty     = (count == '0);
    assign pair.full = (count == (PTR_W+1)'(DEPTH));
    assign push      = pair.valid & ~pair.full;
    assign pop       = i_issue_ready & ~empty;

    //////////////////////////////////////////////////
    // pointers and occupancy
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(push); // wraps, depth is a power of two
            rd_ptr <= rd_ptr + PTR_W'(pop);
            count  <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= '{pc: pair.pc, ir: pair.ir, slot_valid: pair.slot_valid,
                             ecode: pair.ecode};
        end
    end

    //////////////////////////////////////////////////
    // head pair to issue
    //////////////////////////////////////////////////
    assign head = mem[rd_ptr];

    assign o_issue_valid = empty ? 2'b00 : head.slot_valid;
    assign o_issue_pc0   = head.pc;
    assign o_issue_pc1   = head.pc + 32'd4;
    assign o_issue_ir0   = head.ir[0];
    assign o_issue_ir1   = head.ir[1];
    assign o_issue_ecode = head.ecode; // same code on both slots

endmodule

`default_nettype wire

//--- hdl/frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fe_consts.svh"

module frontend_top (
    input  wire logic                  clk,
    input  wire logic                  i_arst_n,
    input  wire logic                  i_exc_valid,
    input  wire logic [`FE_XLEN-1:0]   i_eentry,
    input  wire logic                  i_ertn_valid,
    input  wire logic [`FE_XLEN-1:0]   i_era,
    input  wire logic                  i_br_redirect,
    input  wire logic [`FE_XLEN-1:0]   i_br_target,
    output logic      [`FE_XLEN-1:0]   o_fetch_addr,
    input  wire logic [2*`FE_XLEN-1:0] i_fetch_data,
    input  wire logic                  i_issue_ready,
    output logic      [1:0]            o_issue_valid,
    output logic      [`FE_XLEN-1:0]   o_issue_pc0,
    output logic      [`FE_XLEN-1:0]   o_issue_pc1,
    output logic      [`FE_XLEN-1:0]   o_issue_ir0,
    output logic      [`FE_XLEN-1:0]   o_issue_ir1,
    output fe_pkg::fe_ecode_e          o_issue_ecode
);

    logic [`FE_XLEN-1:0] pc;
    logic                flush;
    logic                pd_redirect;
    logic [`FE_XLEN-1:0] pd_target;

    fetch_pair_if pair_if ();

    assign o_fetch_addr = {pc[`FE_XLEN-1:3], 3'b000}; // memory sees pair address

    fetch_pc_gen u_pc_gen (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_exc_valid   (i_exc_valid),
        .i_eentry      (i_eentry),
        .i_ertn_valid  (i_ertn_valid),
        .i_era         (i_era),
        .i_br_redirect (i_br_redirect),
        .i_br_target   (i_br_target),
        .i_pd_redirect (pd_redirect),
        .i_pd_target   (pd_target),
        .i_stall       (pair_if.full),
        .o_pc          (pc),
        .o_flush       (flush)
    );

    fetch_stage u_fetch_stage (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_pc          (pc),
        .i_fetch_data  (i_fetch_data),
        .i_flush       (flush),
        .o_pd_redirect (pd_redirect),
        .o_pd_target   (pd_target),
        .pair          (pair_if.producer)
    );

    inst_queue #(.DEPTH(`FE_QUEUE_DEPTH)) u_inst_queue (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_flush       (flush),
        .i_issue_ready (i_issue_ready),
        .pair          (pair_if.consumer),
        .o_issue_valid (o_issue_valid),
        .o_issue_pc0   (o_issue_pc0),
        .o_issue_pc1   (o_issue_pc1),
        .o_issue_ir0   (o_issue_ir0),
        .o_issue_ir1   (o_issue_ir1),
        .o_issue_ecode (o_issue_ecode)
    );

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 4, // 8 ns clock
    parameter int RESET_CYCLES = 3
) (
    output logic o_clk,
    output logic o_arst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

    initial begin
        o_arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_arst_n <= 1'b1; // release on a rising edge
    end

endmodule

`default_nettype wire

//--- verif/frontend_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "fe_consts.svh"

module frontend_sva #(
    parameter int DEPTH = 4
) (
    input wire logic                    clk,
    input wire logic                    i_arst_n,
    input wire logic                    i_flush,
    input wire logic                    i_full,
    input wire logic                    i_pair_valid,
    input wire logic [`FE_XLEN-1:0]     i_pair_pc,
    input wire logic [$clog2(DEPTH):0]  i_count,
    input wire logic [1:0]              i_issue_valid
);

    // a pair offered to a full queue waits unchanged in the stage
    a_hold_while_full: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_full && i_pair_valid && !i_flush) |=> (i_pair_valid && $stable(i_pair_pc)))
        else $error("pair dropped or changed while the queue was full");

    // first edge out of reset sees an empty queue
    a_idle_after_reset: assert property (@(posedge clk)
        $rose(i_arst_n) |-> (i_issue_valid == 2'b00))
        else $error("issue valid raised right after reset");

    a_count_bound: assert property (@(posedge clk) disable iff (!i_arst_n)
        int'(i_count) <= DEPTH)
        else $error("queue count above DEPTH");

endmodule

bind inst_queue frontend_sva #(.DEPTH(DEPTH)) u_sva (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_flush       (i_flush),
    .i_full        (pair.full),
    .i_pair_valid  (pair.valid),
    .i_pair_pc     (pair.pc),
    .i_count       (count),
    .i_issue_valid (o_issue_valid)
);

`default_nettype wire

//--- verif/tb_frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fe_consts.svh"

module tb_frontend_top;

    localparam int K_NONE   = 0; // redirect kinds of a table row
    localparam int K_EXC    = 1;
    localparam int K_ERTN   = 2;
    localparam int K_BR     = 3;
    localparam int K_EXC_BR = 4; // exception entry and branch correction together
    localparam int NROWS    = 7;

    typedef struct {
        int                  kind;
        logic [`FE_XLEN-1:0] target;
        logic [`FE_XLEN-1:0] plant_addr;
        logic [`FE_XLEN-1:0] plant_word;
        bit                  rand_ready;
        int                  cycles;
    } row_t;

    typedef struct {
        logic [`FE_XLEN-1:0] pc;
        logic [`FE_XLEN-1:0] ir;
        fe_pkg::fe_ecode_e   ecode;
    } slot_t;

    logic                  clk;
    logic                  arst_n;
    logic                  exc_valid;
    logic [`FE_XLEN-1:0]   eentry;
    logic                  ertn_valid;
    logic [`FE_XLEN-1:0]   era;
    logic                  br_redirect;
    logic [`FE_XLEN-1:0]   br_target;
    logic [`FE_XLEN-1:0]   fetch_addr;
    logic [2*`FE_XLEN-1:0] fetch_data;
    logic                  issue_ready;
    logic [1:0]            issue_valid;
    logic [`FE_XLEN-1:0]   issue_pc0;
    logic [`FE_XLEN-1:0]   issue_pc1;
    logic [`FE_XLEN-1:0]   issue_ir0;
    logic [`FE_XLEN-1:0]   issue_ir1;
    fe_pkg::fe_ecode_e     issue_ecode;
    logic [`FE_XLEN-1:0]   plant_addr;
    logic [`FE_XLEN-1:0]   plant_word;

    row_t  rows [NROWS];
    slot_t exp_q [$];   // expected issue order from the last redirect
    int    errors = 0;
    int    row_slots = 0;
    int    total_slots = 0;
    int    cycle_cnt = 0;
    int    cycle_limit = 0;

    tb_clock_gen u_clk_gen (.o_clk(clk), .o_arst_n(arst_n));

    frontend_top i_dut (
        .clk(clk), .i_arst_n(arst_n),
        .i_exc_valid(exc_valid), .i_eentry(eentry),
        .i_ertn_valid(ertn_valid), .i_era(era),
        .i_br_redirect(br_redirect), .i_br_target(br_target),
        .o_fetch_addr(fetch_addr), .i_fetch_data(fetch_data),
        .i_issue_ready(issue_ready), .o_issue_valid(issue_valid),
        .o_issue_pc0(issue_pc0), .o_issue_pc1(issue_pc1),
        .o_issue_ir0(issue_ir0), .o_issue_ir1(issue_ir1),
        .o_issue_ecode(issue_ecode)
    );

    function automatic logic [31:0] mem_word(input logic [31:0] addr, input logic [31:0] p_addr,
                                             input logic [31:0] p_word);
        mem_word = (addr == p_addr) ? p_word : (addr ^ 32'h5a5a0000);
    endfunction

    always_comb begin
        fetch_data = {mem_word(fetch_addr + 32'd4, plant_addr, plant_word),
                      mem_word(fetch_addr, plant_addr, plant_word)}; // slot 0 low
    end

    //////////////////////////////////////////////////
    // stream model
    //////////////////////////////////////////////////
    function automatic void build_stream(input logic [31:0] start, input logic [31:0] p_addr,
                                         input logic [31:0] p_word);
        logic [31:0]       cur;
        logic [31:0]       base;
        logic [31:0]       spc;
        logic [31:0]       w;
        logic [31:0]       offs;
        logic              adef;
        logic              jumped;
        fe_pkg::fe_ecode_e ec;
        exp_q.delete();
        cur  = start;
        adef = (start[1:0] != 2'b00); // only the redirected pair is misaligned
        while (exp_q.size() < 200) begin
            base   = {cur[31:3], 3'b000};
            jumped = 1'b0;
            for (int s = int'(cur[2]); s < 2 && !jumped; s++) begin
                spc = base + 32'(4 * s);
                w   = mem_word(spc, p_addr, p_word);
                if (adef) ec = fe_pkg::ECODE_ADEF;
                else ec = fe_pkg::ECODE_NONE;
                exp_q.push_back(slot_t'{spc, w, ec});
                if (!adef && (w[31:26] == fe_pkg::OP_B || w[31:26] == fe_pkg::OP_BL)) begin
                    offs   = {{6{w[9]}}, w[9:0], w[25:10]}; // high10 on top of low16
                    cur    = spc + (offs << 2);
                    jumped = 1'b1;
                end
            end
            if (!jumped) cur = base + 32'd8;
            adef = 1'b0;
        end
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic check_slot(input int s, input logic [31:0] pc, input logic [31:0] ir,
                              input fe_pkg::fe_ecode_e ec);
        slot_t e;
        row_slots++;
        assert (exp_q.size() > 0) else begin
            $display("slot %0d issued at %0t ns past the end of the expected stream", s, $time);
            errors++;
        end
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            assert (pc == e.pc) else report_mismatch($sformatf("o_issue_pc%0d", s), pc, e.pc);
            assert (ir == e.ir) else report_mismatch($sformatf("o_issue_ir%0d", s), ir, e.ir);
            assert (ec == e.ecode) else report_mismatch("o_issue_ecode", 32'(ec), 32'(e.ecode));
        end
    endtask

    task automatic start_row(input row_t rw);
        plant_addr  <= rw.plant_addr;
        plant_word  <= rw.plant_word;
        exc_valid   <= (rw.kind == K_EXC || rw.kind == K_EXC_BR);
        eentry      <= rw.target;
        ertn_valid  <= (rw.kind == K_ERTN);
        era         <= rw.target;
        br_redirect <= (rw.kind == K_BR || rw.kind == K_EXC_BR);
        br_target   <= (rw.kind == K_EXC_BR) ? rw.target + 32'h104 : rw.target; // loser
        build_stream(rw.target, rw.plant_addr, rw.plant_word);
    endtask

    // outputs are stable at the falling edge, a pop follows at the next rising edge
    always @(negedge clk) begin
        if (arst_n && issue_ready && !(exc_valid || ertn_valid || br_redirect)) begin
            if (issue_valid[0]) check_slot(0, issue_pc0, issue_ir0, issue_ecode);
            if (issue_valid[1]) check_slot(1, issue_pc1, issue_ir1, issue_ecode);
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: run went past %0d cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////
    initial begin
        int err_base;
        rows[0] = '{K_NONE, `FE_RESET_PC, 32'h0, 32'h0, 1'b0, 40};
        rows[1] = '{K_BR, 32'h1c000100, 32'h0, 32'h0, 1'b1, 80};   // random ready
        rows[2] = '{K_BR, 32'h1c000204, 32'h0, 32'h0, 1'b0, 30};   // odd word target
        rows[3] = '{K_EXC_BR, 32'h1c008000, 32'h0, 32'h0, 1'b0, 30};
        rows[4] = '{K_BR, 32'h1c000400, 32'h1c000410, {6'b010100, 16'd17, 10'd0}, 1'b0, 40};
        rows[5] = '{K_BR, 32'h1c000500, 32'h1c000514, {6'b010101, 16'hfff8, 10'h3ff}, 1'b1, 50};
        rows[6] = '{K_ERTN, 32'h1c000602, 32'h0, 32'h0, 1'b0, 30}; // bit 1 set
        exc_valid   = 1'b0;
        eentry      = '0;
        ertn_valid  = 1'b0;
        era         = '0;
        br_redirect = 1'b0;
        br_target   = '0;
        issue_ready = 1'b0;
        plant_addr  = '0;
        plant_word  = '0;
        void'($urandom(32'he7b30dfd));
        cycle_limit = 50;
        foreach (rows[i]) cycle_limit += rows[i].cycles;
        wait (arst_n === 1'b1);
        for (int r = 0; r < NROWS; r++) begin
            row_slots = 0;
            err_base  = errors;
            for (int c = 0; c < rows[r].cycles; c++) begin
                @(posedge clk);
                if (c == 0) begin
                    start_row(rows[r]);
                end else begin
                    exc_valid   <= 1'b0;
                    ertn_valid  <= 1'b0;
                    br_redirect <= 1'b0;
                end
                issue_ready <= rows[r].rand_ready ? ($urandom() % 32'd2 == 32'd1) : 1'b1;
            end
            assert (row_slots > 0) else begin
                $display("row %0d issued no slots at all", r);
                errors++;
            end
            $display("row %0d done: %0d slots checked, %0d errors", r, row_slots,
                     errors - err_base);
            total_slots += row_slots;
        end
        $display("%0d slots checked over %0d rows, %0d errors", total_slots, NROWS, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- frontend_top.f
+incdir+hdl
hdl/fe_pkg.sv
hdl/fetch_pair_if.sv
hdl/fetch_pc_gen.sv
hdl/fetch_stage.sv
hdl/inst_queue.sv
hdl/frontend_top.sv
verif/tb_clock_gen.sv
verif/frontend_sva.sv
verif/tb_frontend_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f frontend_top.f \
    --top-module tb_frontend_top -o sim_tb

output=$(./obj_dir/sim_tb 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
echo "run_sim.sh: simulation did not pass"
exit 1
